// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bp_pkg.sv
      - rtl/bp_train_if.sv
      - rtl/btb.sv
      - rtl/gshare_pht.sv
      - rtl/bp_ctrl.sv
      - rtl/branch_predictor.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_branch_predictor.sv

// ==== rtl/bp_ctrl.sv ====
// Predictor control: decodes resolved updates, drives table training, forms the prediction
`include "bp_params.svh"

module bp_ctrl (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 upd_valid_i,
    input  logic [31:0]          upd_pc_i,
    input  logic [6:0]           upd_op_i,
    input  logic [31:0]          upd_target_i,
    input  logic                 upd_taken_i,
    input  bp_pkg::pht_idx_t     upd_pht_idx_i,
    input  logic                 ghr_clear_i,
    input  logic                 btb_hit_i,
    input  bp_pkg::branch_kind_t btb_kind_i,
    input  logic [31:0]          btb_target_i,
    input  bp_pkg::btb_entry_t   btb_slot_i,
    input  logic                 pht_taken_i,
    bp_train_if.ctrl             train,
    output logic                 predict_taken_o,
    output logic [31:0]          predict_target_o
);
    import bp_pkg::*;

    branch_kind_t upd_kind;
    branch_kind_t last_kind_q;
    logic         slot_same;

    // JAL and JALR both count as unconditional jumps
    always_comb begin
        case (upd_op_i)
            `BP_OP_JAL,
            `BP_OP_JALR:   upd_kind = KIND_JUMP;
            `BP_OP_BRANCH: upd_kind = KIND_BRANCH;
            default:       upd_kind = KIND_NONE;
        endcase
    end

    // Slot already holds this PC with this target, nothing to write
    assign slot_same = btb_slot_i.valid
                    && (btb_slot_i.tag == upd_pc_i)
                    && (btb_slot_i.target == upd_target_i);

    assign train.btb_we           = upd_valid_i && (upd_kind != KIND_NONE) && !slot_same;
    assign train.btb_entry.valid  = 1'b1;
    assign train.btb_entry.tag    = upd_pc_i;
    assign train.btb_entry.target = upd_target_i;
    assign train.btb_entry.kind   = upd_kind;

    // Only conditional branches train counters and history
    assign train.pht_we    = upd_valid_i && (upd_kind == KIND_BRANCH);
    assign train.pht_idx   = upd_pht_idx_i;
    assign train.taken     = upd_taken_i;
    assign train.ghr_clear = ghr_clear_i;

    // Final prediction from BTB hit and PHT direction
    always_comb begin
        predict_taken_o  = 1'b0;
        predict_target_o = 32'h0;
        if (btb_hit_i) begin
            case (btb_kind_i)
                KIND_JUMP: begin
                    predict_taken_o  = 1'b1;
                    predict_target_o = btb_target_i;
                end
                KIND_BRANCH: begin
                    predict_taken_o  = pht_taken_i;
                    predict_target_o = btb_target_i;
                end
                default: begin
                    predict_taken_o  = 1'b0;
                    predict_target_o = 32'h0;
                end
            endcase
        end
    end

    // Kind of the most recent accepted update
    always_ff @(posedge clk) begin
        if (reset_i) begin
            last_kind_q <= KIND_NONE;
        end else if (upd_valid_i) begin
            last_kind_q <= upd_kind;
        end
    end

    // An allocation always belongs to a control transfer update
    alloc_kind_a: assert property (
        @(posedge clk) disable iff (reset_i)
        train.btb_we |=> (last_kind_q != KIND_NONE)
    ) else $error("bp_ctrl: BTB allocation for a non-control update");

    train_valid_a: assert property (
        @(posedge clk) disable iff (reset_i)
        train.pht_we |-> upd_valid_i
    ) else $error("bp_ctrl: counter training without an update strobe");

endmodule

// ==== rtl/bp_params.svh ====
// Table sizes and RV32 opcode values for the branch predictor, included by package and RTL
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// Number of direct-mapped BTB slots, must be a power of two
`define BP_BTB_ENTRIES 32

// History length, also the PHT index width (2**5 = 32 counters)
`define BP_GHR_BITS 5

// Counters in the pattern history table
`define BP_PHT_ENTRIES (1 << `BP_GHR_BITS)

// RV32 major opcodes of control transfer instructions
`define BP_OP_JAL    7'b1101111
`define BP_OP_JALR   7'b1100111
`define BP_OP_BRANCH 7'b1100011

`endif

// ==== rtl/bp_pkg.sv ====
// Shared types of the branch predictor, imported by the interface and every RTL module
`include "bp_params.svh"

package bp_pkg;

    // What a BTB slot holds
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,
        KIND_JUMP   = 2'd1,
        KIND_BRANCH = 2'd2
    } branch_kind_t;

    // Slot index, PC bits above the word offset
    typedef logic [$clog2(`BP_BTB_ENTRIES)-1:0] btb_idx_t;

    // Counter index, PC bits XOR global history
    typedef logic [`BP_GHR_BITS-1:0] pht_idx_t;

    // One BTB slot, tagged with the full PC
    typedef struct packed {
        logic         valid;
        logic [31:0]  tag;
        logic [31:0]  target;
        branch_kind_t kind;
    } btb_entry_t;

endpackage

// ==== rtl/bp_train_if.sv ====
// Training request from the predictor controller to the BTB and the gshare table
interface bp_train_if;
    import bp_pkg::*;

    // BTB allocation
    logic       btb_we;
    btb_entry_t btb_entry;

    // Counter training and history control
    logic       pht_we;
    pht_idx_t   pht_idx;
    logic       taken;
    logic       ghr_clear;

    modport ctrl (
        output btb_we,
        output btb_entry,
        output pht_we,
        output pht_idx,
        output taken,
        output ghr_clear
    );

    modport btb (
        input btb_we,
        input btb_entry
    );

    modport pht (
        input pht_we,
        input pht_idx,
        input taken,
        input ghr_clear
    );

endinterface

// ==== rtl/branch_predictor.sv ====
// Top level of the front-end branch predictor, instantiated by the fetch and execute stages
module branch_predictor (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [31:0]      pc_i,
    input  logic             upd_valid_i,
    input  logic [31:0]      upd_pc_i,
    input  logic [6:0]       upd_op_i,
    input  logic [31:0]      upd_target_i,
    input  logic             upd_taken_i,
    input  bp_pkg::pht_idx_t upd_pht_idx_i,
    input  logic             ghr_clear_i,
    output logic             predict_taken_o,
    output logic [31:0]      predict_target_o,
    output bp_pkg::pht_idx_t pht_idx_o
);
    import bp_pkg::*;

    // Lookup results
    logic         btb_hit;
    branch_kind_t btb_kind;
    logic [31:0]  btb_target;
    btb_entry_t   btb_slot;
    logic         pht_taken;

    bp_train_if train_if ();

    bp_ctrl bp_ctrl_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_op_i         (upd_op_i),
        .upd_target_i     (upd_target_i),
        .upd_taken_i      (upd_taken_i),
        .upd_pht_idx_i    (upd_pht_idx_i),
        .ghr_clear_i      (ghr_clear_i),
        .btb_hit_i        (btb_hit),
        .btb_kind_i       (btb_kind),
        .btb_target_i     (btb_target),
        .btb_slot_i       (btb_slot),
        .pht_taken_i      (pht_taken),
        .train            (train_if.ctrl),
        .predict_taken_o  (predict_taken_o),
        .predict_target_o (predict_target_o)
    );

    btb btb_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .pc_i     (pc_i),
        .upd_pc_i (upd_pc_i),
        .train    (train_if.btb),
        .hit_o    (btb_hit),
        .kind_o   (btb_kind),
        .target_o (btb_target),
        .slot_o   (btb_slot)
    );

    gshare_pht gshare_pht_i (
        .clk     (clk),
        .reset_i (reset_i),
        .pc_i    (pc_i),
        .train   (train_if.pht),
        .taken_o (pht_taken),
        .idx_o   (pht_idx_o)
    );

endmodule

// ==== rtl/btb.sv ====
// Direct-mapped branch target buffer with combinational lookup and single-edge allocation
`include "bp_params.svh"

module btb (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic [31:0]          pc_i,
    input  logic [31:0]          upd_pc_i,
    bp_train_if.btb              train,
    output logic                 hit_o,
    output bp_pkg::branch_kind_t kind_o,
    output logic [31:0]          target_o,
    output bp_pkg::btb_entry_t   slot_o
);
    import bp_pkg::*;

    localparam int IDX_BITS = $bits(btb_idx_t);

    // Valid bits are kept apart so that reset only touches one vector
    logic [`BP_BTB_ENTRIES-1:0] valid_q;
    btb_entry_t                 entry_q [`BP_BTB_ENTRIES];

    btb_idx_t   lookup_idx;
    btb_idx_t   upd_idx;
    btb_entry_t lookup_entry;

    // Word aligned PCs, so bits 1:0 carry no index information
    assign lookup_idx = pc_i[IDX_BITS+1:2];
    assign upd_idx    = upd_pc_i[IDX_BITS+1:2];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (train.btb_we) begin
            valid_q[upd_idx] <= train.btb_entry.valid;
        end
    end

    // Payload storage, meaningful only where the valid bit is set
    always_ff @(posedge clk) begin
        if (train.btb_we) begin
            entry_q[upd_idx] <= train.btb_entry;
        end
    end

    always_comb begin
        lookup_entry       = entry_q[lookup_idx];
        lookup_entry.valid = valid_q[lookup_idx];
    end

    // Full-PC tag compare, so aliasing PCs never hit
    assign hit_o    = lookup_entry.valid && (lookup_entry.tag == pc_i);
    assign kind_o   = lookup_entry.kind;
    assign target_o = lookup_entry.target;

    // Stored slot at the update index, used by the controller to skip redundant writes
    always_comb begin
        slot_o       = entry_q[upd_idx];
        slot_o.valid = valid_q[upd_idx];
    end

    // A valid slot always came from a jump or branch allocation
    hit_kind_a: assert property (
        @(posedge clk) disable iff (reset_i)
        hit_o |-> (kind_o != KIND_NONE)
    ) else $error("btb: hit on slot %0d with kind none", lookup_idx);

endmodule

// ==== rtl/gshare_pht.sv ====
// Gshare direction predictor with global history and 2-bit saturating counters
`include "bp_params.svh"

module gshare_pht (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [31:0]      pc_i,
    bp_train_if.pht          train,
    output logic             taken_o,
    output bp_pkg::pht_idx_t idx_o
);
    import bp_pkg::*;

    localparam int GHR_BITS = `BP_GHR_BITS;

    // Global history, newest outcome at the MSB
    logic [GHR_BITS-1:0] ghr_q;
    logic [1:0]          pht_q [`BP_PHT_ENTRIES];

    pht_idx_t   read_idx;
    logic [1:0] cnt_cur;
    logic [1:0] cnt_next;

    // Hash of PC word bits and history
    assign read_idx = pc_i[GHR_BITS+1:2] ^ ghr_q;
    assign idx_o    = read_idx;

    // Counter MSB is the direction
    assign taken_o = pht_q[read_idx][1];

    // Saturating step of the counter being trained
    always_comb begin
        cnt_cur  = pht_q[train.pht_idx];
        cnt_next = cnt_cur;
        if (train.taken) begin
            if (cnt_cur != 2'b11) begin
                cnt_next = cnt_cur + 2'd1;
            end
        end else begin
            if (cnt_cur != 2'b00) begin
                cnt_next = cnt_cur - 2'd1;
            end
        end
    end

    // All counters start strongly not taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b00;
            end
        end else if (train.pht_we) begin
            pht_q[train.pht_idx] <= cnt_next;
        end
    end

    // Flush clear wins over a shift in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i || train.ghr_clear) begin
            ghr_q <= '0;
        end else if (train.pht_we) begin
            ghr_q <= {train.taken, ghr_q[GHR_BITS-1:1]};
        end
    end

    // Execute stage must stay quiet while the predictor is in reset
    no_train_in_reset_a: assert property (
        @(posedge clk) reset_i |-> !train.pht_we
    ) else $error("gshare_pht: counter write requested during reset");

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/bp_pkg.sv
rtl/bp_train_if.sv
rtl/btb.sv
rtl/gshare_pht.sv
rtl/bp_ctrl.sv
rtl/branch_predictor.sv
testbench/tb_branch_predictor.sv

// ==== testbench/tb_branch_predictor.sv ====
// Table-driven testbench for branch_predictor, run as the simulation top with sim.f
`include "bp_params.svh"

module tb_branch_predictor;
    timeunit 1ns;
    timeprecision 1ps;
    import bp_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;

    // Word-aligned PCs and targets; A and its alias share BTB index 2
    localparam logic [31:0] PC_A       = 32'h0000_1008;
    localparam logic [31:0] PC_A_ALIAS = 32'h0000_1088;
    localparam logic [31:0] PC_B       = 32'h0000_1010;
    localparam logic [31:0] PC_C       = 32'h0000_1020;
    localparam logic [31:0] TGT_T      = 32'h0000_2000;
    localparam logic [31:0] TGT_U      = 32'h0000_3000;
    localparam logic [31:0] TGT_V      = 32'h0000_4000;
    localparam logic [6:0]  OP_ALU     = 7'b0110011;

    // PC bits 6:2, and B's index once a taken outcome sits in the history MSB
    localparam pht_idx_t IDX_A      = 5'd2;
    localparam pht_idx_t IDX_B      = 5'd4;
    localparam pht_idx_t IDX_C      = 5'd8;
    localparam pht_idx_t IDX_B_HIST = 5'd20;

    typedef struct packed {
        logic [31:0] pc;
        logic        upd_valid;
        logic [6:0]  upd_op;
        logic [31:0] upd_pc;
        logic [31:0] upd_target;
        logic        upd_taken;
        pht_idx_t    upd_pht_idx;
        logic        ghr_clear;
        logic        exp_taken;
        logic [31:0] exp_target;
        pht_idx_t    exp_idx;
    } row_t;

    logic        clk = 1'b0;
    logic        reset_i;
    logic [31:0] pc_i;
    logic        upd_valid_i;
    logic [31:0] upd_pc_i;
    logic [6:0]  upd_op_i;
    logic [31:0] upd_target_i;
    logic        upd_taken_i;
    pht_idx_t    upd_pht_idx_i;
    logic        ghr_clear_i;
    logic        predict_taken_o;
    logic [31:0] predict_target_o;
    pht_idx_t    pht_idx_o;

    row_t   rows[$];
    integer seed = 32'h4328_a5fc;
    int     cycle_count = 0;
    int     timeout_limit = 1000;

    branch_predictor branch_predictor_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic add_row(input logic [31:0] pc, input logic upd_valid, input logic [6:0] op,
                           input logic [31:0] upd_pc, input logic [31:0] tgt,
                           input logic taken, input pht_idx_t pidx, input logic clr,
                           input logic exp_taken, input logic [31:0] exp_target,
                           input pht_idx_t exp_idx);
        row_t r;
        r = '{pc, upd_valid, op, upd_pc, tgt, taken, pidx, clr, exp_taken, exp_target, exp_idx};
        rows.push_back(r);
    endtask

    task automatic add_lookup(input logic [31:0] pc, input logic clr, input logic exp_taken,
                              input logic [31:0] exp_target, input pht_idx_t exp_idx);
        add_row(pc, 1'b0, 7'h0, 32'h0, 32'h0, 1'b0, '0, clr, exp_taken, exp_target, exp_idx);
    endtask

    function automatic logic is_trained_idx(input logic [31:0] pc);
        return (pc[6:2] == IDX_A) || (pc[6:2] == IDX_B) || (pc[6:2] == IDX_C);
    endfunction

    // Random miss; only placed where history is zero, so the index is the PC bits
    task automatic add_filler();
        logic [31:0] pc;
        pc = $random(seed) & 32'hFFFF_FFFC;
        while (is_trained_idx(pc)) begin
            pc = $random(seed) & 32'hFFFF_FFFC;
        end
        add_lookup(pc, 1'b0, 1'b0, 32'h0, pc[6:2]);
    endtask

    task automatic build_table();
        // Cold state
        add_filler();
        add_filler();
        add_lookup(PC_A, 1'b0, 1'b0, 32'h0, IDX_A);
        // Jump allocation, then alias with a different tag
        add_row(PC_A, 1'b1, `BP_OP_JAL, PC_A, TGT_T, 1'b1, '0, 1'b0, 1'b0, 32'h0, IDX_A);
        add_lookup(PC_A, 1'b0, 1'b1, TGT_T, IDX_A);
        add_lookup(PC_A_ALIAS, 1'b0, 1'b0, 32'h0, IDX_A);
        // Branch B with history held at zero; counter 0 -> 1 -> 2 -> 3 (saturates)
        add_row(PC_B, 1'b1, `BP_OP_BRANCH, PC_B, TGT_U, 1'b1, IDX_B, 1'b1, 1'b0, 32'h0, IDX_B);
        add_row(PC_B, 1'b1, `BP_OP_BRANCH, PC_B, TGT_U, 1'b1, IDX_B, 1'b1, 1'b0, TGT_U, IDX_B);
        for (int i = 0; i < 4; i++) begin
            add_row(PC_B, 1'b1, `BP_OP_BRANCH, PC_B, TGT_U, 1'b1, IDX_B, 1'b1,
                    1'b1, TGT_U, IDX_B);
        end
        // Three not-taken updates, 3 -> 2 -> 1 -> 0
        add_row(PC_B, 1'b1, `BP_OP_BRANCH, PC_B, TGT_U, 1'b0, IDX_B, 1'b1, 1'b1, TGT_U, IDX_B);
        add_row(PC_B, 1'b1, `BP_OP_BRANCH, PC_B, TGT_U, 1'b0, IDX_B, 1'b1, 1'b1, TGT_U, IDX_B);
        add_row(PC_B, 1'b1, `BP_OP_BRANCH, PC_B, TGT_U, 1'b0, IDX_B, 1'b1, 1'b0, TGT_U, IDX_B);
        add_lookup(PC_B, 1'b0, 1'b0, TGT_U, IDX_B);
        // ALU update must neither allocate nor train
        add_row(PC_C, 1'b1, OP_ALU, PC_C, 32'h0000_5000, 1'b1, IDX_B, 1'b0, 1'b0, 32'h0, IDX_C);
        add_lookup(PC_C, 1'b0, 1'b0, 32'h0, IDX_C);
        add_lookup(PC_B, 1'b0, 1'b0, TGT_U, IDX_B);
        // Taken branch without clear puts a 1 in the history MSB
        add_row(PC_B, 1'b1, `BP_OP_BRANCH, PC_B, TGT_U, 1'b1, IDX_B, 1'b0, 1'b0, TGT_U, IDX_B);
        add_lookup(PC_B, 1'b0, 1'b0, TGT_U, IDX_B_HIST);
        add_lookup(PC_B, 1'b1, 1'b0, TGT_U, IDX_B_HIST);
        add_lookup(PC_B, 1'b0, 1'b0, TGT_U, IDX_B);
        add_filler();
        // New jump target at A replaces the old one
        add_row(PC_A, 1'b1, `BP_OP_JALR, PC_A, TGT_V, 1'b1, '0, 1'b0, 1'b1, TGT_T, IDX_A);
        add_lookup(PC_A, 1'b0, 1'b1, TGT_V, IDX_A);
        add_filler();
        add_lookup(PC_A_ALIAS, 1'b0, 1'b0, 32'h0, IDX_A);
    endtask

    task automatic drive_row(input row_t r);
        pc_i          = r.pc;
        upd_valid_i   = r.upd_valid;
        upd_pc_i      = r.upd_pc;
        upd_op_i      = r.upd_op;
        upd_target_i  = r.upd_target;
        upd_taken_i   = r.upd_taken;
        upd_pht_idx_i = r.upd_pht_idx;
        ghr_clear_i   = r.ghr_clear;
    endtask

    task automatic check_row(input int n, input row_t r);
        assert (predict_taken_o === r.exp_taken) else
            fail_run($sformatf("mismatch at %0t ns row %0d: predict_taken_o got %0b expected %0b",
                               $time, n, predict_taken_o, r.exp_taken));
        assert (predict_target_o === r.exp_target) else
            fail_run($sformatf("mismatch at %0t ns row %0d: predict_target_o got %h expected %h",
                               $time, n, predict_target_o, r.exp_target));
        assert (pht_idx_o === r.exp_idx) else
            fail_run($sformatf("mismatch at %0t ns row %0d: pht_idx_o got %0d expected %0d",
                               $time, n, pht_idx_o, r.exp_idx));
    endtask

    // Run limit in cycles
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            fail_run($sformatf("timeout: test did not finish within %0d cycles", timeout_limit));
        end
    end

    initial begin
        reset_i = 1'b1;
        drive_row('0);
        build_table();
        timeout_limit = rows.size() + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        foreach (rows[i]) begin
            drive_row(rows[i]);
            // Sample just before the rising edge that applies this row's update
            #(CLK_PERIOD / 2 - 1);
            check_row(i, rows[i]);
            @(negedge clk);
        end
        drive_row('0);
        $display("Done: no errors");
        $finish;
    end

endmodule
